/* bench/write_buffer_tb.sv */
//////////////////////////////////////////////////////////////////////
// directed testbench for the write buffer
// a cycle model predicts busy, read responses and memory writes;
// run it as the top module with the file list
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module write_buffer_tb
  import wbuf_pkg::*;
;

  localparam int PERIOD      = 40;
  // rough length of all tests in cycles, plus slack
  localparam int TEST_CYCLES = 100;
  localparam int MARGIN      = 40;

  logic       phi1;
  logic       rst_n;
  cache_req_t cache_req;
  logic       mem_ready;
  logic       busy;
  cache_rsp_t cache_rsp;
  mem_wr_t    mem_wr;

  integer     seed;
  logic       ready_level;
  logic       last_busy;
  int         pulse_count;
  addr_t      last_addr;
  data_t      last_data;

  // model: buffered entries in drain order
  addr_t      q_addr [$];
  data_t      q_data [$];
  // what the DUT must show at the next falling edge
  logic       exp_rsp_valid;
  logic       exp_rsp_hit;
  data_t      exp_rsp_data;
  logic       exp_mem_valid;
  addr_t      exp_mem_addr;
  data_t      exp_mem_data;

  write_buffer i_write_buffer (
    .phi1      (phi1),
    .rst_n     (rst_n),
    .cache_req (cache_req),
    .mem_ready (mem_ready),
    .busy      (busy),
    .cache_rsp (cache_rsp),
    .mem_wr    (mem_wr)
  );

  always #(PERIOD/2) phi1 = ~phi1;

  //////////////////////////////////////////////////////////////////////
  // checking
  //////////////////////////////////////////////////////////////////////

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopping after first error");
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
      fail_run($sformatf("FAILED at %0t ns: %s is %0h, expected %0h", $time, what, got, exp));
  endtask

  function automatic int find_entry(input addr_t a);
    for (int i = 0; i < q_addr.size(); i++)
    begin
      if (q_addr[i] == a)
        return i;
    end
    return -1;
  endfunction

  function automatic data_t next_data();
    return data_t'($random(seed));
  endfunction

  // memory writes and read responses against the model
  task automatic watch_outputs();
    if (mem_wr.valid && !exp_mem_valid)
      fail_run($sformatf("unexpected memory write to address %0h at %0t ns",
                         mem_wr.addr, $time));
    if (!mem_wr.valid && exp_mem_valid)
      fail_run($sformatf("memory write to address %0h missing at %0t ns",
                         exp_mem_addr, $time));
    if (mem_wr.valid)
    begin
      check_eq(mem_wr.addr, exp_mem_addr, "memory address");
      check_eq(mem_wr.data, exp_mem_data, "memory data");
      pulse_count++;
      last_addr = mem_wr.addr;
      last_data = mem_wr.data;
    end
    check_eq(cache_rsp.valid, exp_rsp_valid, "response valid");
    if (exp_rsp_valid)
    begin
      check_eq(cache_rsp.hit, exp_rsp_hit, "response hit");
      check_eq(cache_rsp.data, exp_rsp_data, "response data");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // one bus cycle with model update
  //////////////////////////////////////////////////////////////////////

  task automatic cycle(input logic wr, input logic rd, input addr_t addr, input data_t data);
    int   idx;
    logic exp_busy;
    @(negedge phi1);
    watch_outputs();
    cache_req.wr   = wr;
    cache_req.rd   = rd;
    cache_req.addr = addr;
    cache_req.data = data;
    mem_ready      = ready_level;
    // busy is combinational, sample mid cycle
    #(PERIOD/4);
    idx      = find_entry(addr);
    exp_busy = wr && (idx < 0) && (q_addr.size() == ENTRIES);
    check_eq(busy, exp_busy, "busy");
    last_busy     = busy;
    exp_rsp_valid = 1'b0;
    exp_mem_valid = 1'b0;
    if (wr)
    begin
      // merge, allocate, or refuse on full
      if (idx >= 0)
        q_data[idx] = data;
      else if (!exp_busy)
      begin
        q_addr.push_back(addr);
        q_data.push_back(data);
      end
    end
    else if (rd)
    begin
      exp_rsp_valid = 1'b1;
      exp_rsp_hit   = (idx >= 0);
      exp_rsp_data  = (idx >= 0) ? q_data[idx] : '0;
    end
    else if (ready_level && q_addr.size() > 0)
    begin
      // idle cycle with memory ready drains the head
      exp_mem_valid = 1'b1;
      exp_mem_addr  = q_addr.pop_front();
      exp_mem_data  = q_data.pop_front();
    end
  endtask

  task automatic write_word(input addr_t addr, input data_t data);
    cycle(1'b1, 1'b0, addr, data);
  endtask

  task automatic read_word(input addr_t addr);
    cycle(1'b0, 1'b1, addr, '0);
  endtask

  task automatic idle_cycle();
    cycle(1'b0, 1'b0, '0, '0);
  endtask

  // idle until model and DUT are both empty
  task automatic drain_all();
    int guard;
    guard       = 0;
    ready_level = 1'b1;
    while (q_addr.size() > 0 || exp_mem_valid || exp_rsp_valid)
    begin
      if (guard == 3*ENTRIES + 4)
        fail_run("the buffer did not drain to memory in time");
      idle_cycle();
      guard++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_fifo_drain();
    int start;
    ready_level = 1'b0;
    write_word(8'h10, next_data());
    write_word(8'h20, next_data());
    write_word(8'h30, next_data());
    // memory not ready, nothing may leave
    idle_cycle();
    start = pulse_count;
    drain_all();
    check_eq(pulse_count - start, 3, "drain pulse count");
  endtask

  task automatic test_merge();
    int    start;
    data_t d;
    ready_level = 1'b0;
    d = next_data();
    write_word(8'h55, next_data());
    write_word(8'h55, d);
    start = pulse_count;
    drain_all();
    check_eq(pulse_count - start, 1, "merged pulse count");
    check_eq(last_data, d, "merged data");
  endtask

  task automatic test_read();
    ready_level = 1'b0;
    write_word(8'h61, next_data());
    write_word(8'h62, next_data());
    write_word(8'h61, next_data());
    // hit on the merged word, then a miss
    read_word(8'h61);
    read_word(8'h7f);
    drain_all();
  endtask

  task automatic test_full_stall();
    data_t held;
    int    tries;
    ready_level = 1'b0;
    held = next_data();
    for (int i = 0; i < ENTRIES; i++)
      write_word(addr_t'(8'h41 + i), next_data());
    repeat (3)
    begin
      write_word(8'h99, held);
      check_eq(last_busy, 1'b1, "busy on full miss");
    end
    write_word(8'h42, next_data());
    check_eq(last_busy, 1'b0, "busy on full hit");
    // let one drain through, then retry the held write
    ready_level = 1'b1;
    tries       = 0;
    last_busy   = 1'b1;
    while (last_busy)
    begin
      if (tries == 8)
        fail_run("the held write was never accepted");
      idle_cycle();
      write_word(8'h99, held);
      tries++;
    end
    drain_all();
    check_eq(last_addr, 8'h99, "last drained address");
    check_eq(last_data, held, "last drained data");
  endtask

  task automatic test_priority();
    int start;
    ready_level = 1'b0;
    write_word(8'h80, next_data());
    write_word(8'h81, next_data());
    write_word(8'h82, next_data());
    ready_level = 1'b1;
    start = pulse_count;
    // four write addresses only, so the buffer never refuses
    repeat (40)
    begin
      if ($random(seed) & 1)
        write_word(addr_t'(8'h80 + ($random(seed) & 3)), next_data());
      else
        read_word(addr_t'(8'h80 + ($random(seed) & 7)));
    end
    check_eq(pulse_count - start, 0, "pulses during requests");
    drain_all();
    check_eq(pulse_count - start > 0, 1'b1, "drain after requests");
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    phi1          = 1'b0;
    rst_n         = 1'b0;
    cache_req     = '0;
    mem_ready     = 1'b0;
    seed          = 32'hfe98_3c70;
    ready_level   = 1'b0;
    last_busy     = 1'b0;
    pulse_count   = 0;
    exp_rsp_valid = 1'b0;
    exp_mem_valid = 1'b0;
    repeat (2) @(posedge phi1);
    @(negedge phi1);
    rst_n = 1'b1;
    check_eq(busy, 1'b0, "busy after reset");
    check_eq(cache_rsp.valid, 1'b0, "response valid after reset");
    check_eq(mem_wr.valid, 1'b0, "memory valid after reset");
    test_fifo_drain();
    test_merge();
    test_read();
    test_full_stall();
    test_priority();
    $display("sim passed");
    $finish;
  end

  initial
  begin
    #((TEST_CYCLES + MARGIN) * PERIOD);
    fail_run("timeout, the tests did not finish");
  end

endmodule

/* src/entry_cam.sv */
//////////////////////////////////////////////////////////////////////
// tag and valid storage for every buffer entry
// gives a combinational match vector of valid entries whose tag
// equals the lookup address; tags and valid bits change at the edge
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module entry_cam
  import wbuf_pkg::*;
(
  input  logic  phi1,
  input  logic  rst_n,
  input  addr_t lookup_addr,
  input  line_t wr_lines,
  input  logic  wr_tag,
  input  logic  set_valid,
  input  line_t clr_lines,
  output addr_t tags_out [ENTRIES],
  output line_t match_lines
);

  addr_t tags [ENTRIES];
  line_t valid;

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  // tag words, written with the lookup address on allocation
  always_ff @(posedge phi1)
  begin
    for (int i = 0; i < ENTRIES; i++)
    begin
      if (wr_tag && wr_lines[i])
        tags[i] <= lookup_addr;
    end
  end

  // valid bits
  always_ff @(posedge phi1 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      valid <= '0;
    end
    else
    begin
      // set on allocate, clear on drain; never the same entry at once
      if (set_valid)
        valid <= (valid | wr_lines) & ~clr_lines;
      else
        valid <= valid & ~clr_lines;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // associative lookup
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < ENTRIES; i++)
    begin
      // stale tags in empty slots are masked off here
      match_lines[i] = valid[i] && (tags[i] == lookup_addr);
    end
  end

  // head tag is picked in the datapath
  assign tags_out = tags;

endmodule

/* src/entry_regfile.sv */
//////////////////////////////////////////////////////////////////////
// data words of the buffer entries
// one write port and one read port, each selected by one-hot lines;
// the read port gives zero when no line is selected
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module entry_regfile
  import wbuf_pkg::*;
(
  input  logic  phi1,
  input  logic  rst_n,
  input  line_t wr_lines,
  input  data_t wr_data,
  input  logic  wr_en,
  input  line_t rd_lines,
  output data_t rd_data
);

  data_t words [ENTRIES];

  // write port
  always_ff @(posedge phi1 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < ENTRIES; i++)
        words[i] <= '0;
    end
    else if (wr_en)
    begin
      for (int i = 0; i < ENTRIES; i++)
      begin
        if (wr_lines[i])
          words[i] <= wr_data;
      end
    end
  end

  // read port, and-or mux over the one-hot lines
  always_comb
  begin
    rd_data = '0;
    for (int i = 0; i < ENTRIES; i++)
    begin
      if (rd_lines[i])
        rd_data = rd_data | words[i];
    end
  end

endmodule

/* src/ring_pointer.sv */
//////////////////////////////////////////////////////////////////////
// one-hot rotating entry pointer
// instanced twice in the datapath, once as head and once as tail
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module ring_pointer
  import wbuf_pkg::*;
(
  input  logic  phi1,
  input  logic  rst_n,
  input  logic  shift,
  output line_t lines
);

  // starts at entry 0, rotates up by one per shift cycle
  always_ff @(posedge phi1 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      lines <= line_t'(1);
    end
    else if (shift)
    begin
      // top entry wraps back to entry 0
      lines <= {lines[ENTRIES-2:0], lines[ENTRIES-1]};
    end
  end

endmodule

/* src/wbuf_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// write buffer controller
// picks one operation per cycle by fixed priority and tracks the
// number of occupied entries; combinational apart from the count
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module wbuf_ctrl
  import wbuf_pkg::*;
(
  input  logic       phi1,
  input  logic       rst_n,
  input  cache_req_t req,
  input  logic       match,
  input  logic       mem_ready,
  output wb_op_t     op,
  output logic       busy
);

  count_t count;
  logic   full;
  logic   empty;

  assign full  = (count == count_t'(ENTRIES));
  assign empty = (count == '0);

  //////////////////////////////////////////////////////////////////////
  // operation choice
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    op   = OP_NONE;
    busy = 1'b0;
    if (req.wr)
    begin
      // cache write always wins the cycle
      if (match)
        op = OP_WR_HIT;
      else if (!full)
        op = OP_WR_ALLOC;
      else
        // miss on full buffer, cache holds and retries
        busy = 1'b1;
    end
    else if (req.rd)
    begin
      op = OP_RD;
    end
    else if (!empty && mem_ready)
    begin
      // drain only in otherwise idle cycles
      op = OP_DRAIN;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // occupancy
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge phi1 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      count <= '0;
    end
    else
    begin
      // alloc and drain are exclusive, so one step at most
      case (op)
        OP_WR_ALLOC: count <= count + count_t'(1);
        OP_DRAIN:    count <= count - count_t'(1);
        default:     count <= count;
      endcase
    end
  end

endmodule

/* src/wbuf_datapath.sv */
//////////////////////////////////////////////////////////////////////
// write buffer datapath
// head and tail pointers, tag CAM and data register file; steers
// the entry lines from the op and registers the cache response and
// the memory write for one cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module wbuf_datapath
  import wbuf_pkg::*;
(
  input  logic       phi1,
  input  logic       rst_n,
  input  cache_req_t req,
  input  wb_op_t     op,
  output logic       match,
  output cache_rsp_t rsp,
  output mem_wr_t    mem
);

  line_t head_lines;
  line_t tail_lines;
  line_t match_lines;
  line_t wr_lines;
  line_t rd_lines;
  line_t clr_lines;
  addr_t tags [ENTRIES];
  addr_t head_tag;
  data_t rd_data;
  logic  do_alloc;
  logic  do_write;
  logic  do_drain;

  assign do_alloc = (op == OP_WR_ALLOC);
  assign do_write = (op == OP_WR_HIT) || do_alloc;
  assign do_drain = (op == OP_DRAIN);

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  // head moves on drains, tail on allocations
  ring_pointer i_head (
    .phi1  (phi1),
    .rst_n (rst_n),
    .shift (do_drain),
    .lines (head_lines)
  );

  ring_pointer i_tail (
    .phi1  (phi1),
    .rst_n (rst_n),
    .shift (do_alloc),
    .lines (tail_lines)
  );

  entry_cam i_cam (
    .phi1        (phi1),
    .rst_n       (rst_n),
    .lookup_addr (req.addr),
    .wr_lines    (wr_lines),
    .wr_tag      (do_alloc),
    .set_valid   (do_alloc),
    .clr_lines   (clr_lines),
    .tags_out    (tags),
    .match_lines (match_lines)
  );

  entry_regfile i_regfile (
    .phi1     (phi1),
    .rst_n    (rst_n),
    .wr_lines (wr_lines),
    .wr_data  (req.data),
    .wr_en    (do_write),
    .rd_lines (rd_lines),
    .rd_data  (rd_data)
  );

  //////////////////////////////////////////////////////////////////////
  // line steering
  //////////////////////////////////////////////////////////////////////

  assign match = |match_lines;

  // merge writes over the matching slot, fresh writes go to tail
  assign wr_lines  = (op == OP_WR_HIT) ? match_lines :
                     do_alloc          ? tail_lines  : '0;
  // a read miss selects nothing, which reads back zero
  assign rd_lines  = (op == OP_RD) ? match_lines :
                     do_drain      ? head_lines  : '0;
  assign clr_lines = do_drain ? head_lines : '0;

  // tag of the head entry for the memory address
  always_comb
  begin
    head_tag = '0;
    for (int i = 0; i < ENTRIES; i++)
    begin
      if (head_lines[i])
        head_tag = head_tag | tags[i];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge phi1 or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rsp <= '0;
      mem <= '0;
    end
    else
    begin
      // both pulse for a single cycle
      rsp.valid <= (op == OP_RD);
      rsp.hit   <= (op == OP_RD) && match;
      rsp.data  <= (op == OP_RD) ? rd_data : '0;
      mem.valid <= do_drain;
      mem.addr  <= do_drain ? head_tag : '0;
      mem.data  <= do_drain ? rd_data : '0;
    end
  end

endmodule

/* src/wbuf_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared widths, types and bus structs for the write buffer
// every write buffer module imports this package in its header
//////////////////////////////////////////////////////////////////////

package wbuf_pkg;

  // buffer geometry
  localparam int ENTRIES = 4;
  localparam int ADDR_W  = 8;
  localparam int DATA_W  = 8;
  // occupancy count, must hold 0..ENTRIES
  localparam int CNT_W   = 3;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [DATA_W-1:0]  data_t;
  // one-hot or zero entry select
  typedef logic [ENTRIES-1:0] line_t;
  typedef logic [CNT_W-1:0]   count_t;

  // operation picked for one cycle
  typedef enum logic [2:0] {
    OP_NONE,
    OP_WR_HIT,
    OP_WR_ALLOC,
    OP_RD,
    OP_DRAIN
  } wb_op_t;

  // request from the cache, wr and rd never high together
  typedef struct packed {
    logic  wr;
    logic  rd;
    addr_t addr;
    data_t data;
  } cache_req_t;

  // read response back to the cache
  typedef struct packed {
    logic  valid;
    logic  hit;
    data_t data;
  } cache_rsp_t;

  // single-cycle write to system memory
  typedef struct packed {
    logic  valid;
    addr_t addr;
    data_t data;
  } mem_wr_t;

endpackage

/* src/write_buffer.sv */
//////////////////////////////////////////////////////////////////////
// write buffer top level, between a write-through cache and memory
// four merging entries drained to memory in allocation order
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module write_buffer
  import wbuf_pkg::*;
(
  input  logic       phi1,
  input  logic       rst_n,
  input  cache_req_t cache_req,
  input  logic       mem_ready,
  output logic       busy,
  output cache_rsp_t cache_rsp,
  output mem_wr_t    mem_wr
);

  // controller to datapath
  wb_op_t op;
  // datapath to controller
  logic   match;

  wbuf_ctrl i_ctrl (
    .phi1      (phi1),
    .rst_n     (rst_n),
    .req       (cache_req),
    .match     (match),
    .mem_ready (mem_ready),
    .op        (op),
    .busy      (busy)
  );

  wbuf_datapath i_datapath (
    .phi1  (phi1),
    .rst_n (rst_n),
    .req   (cache_req),
    .op    (op),
    .match (match),
    .rsp   (cache_rsp),
    .mem   (mem_wr)
  );

endmodule

/* write_buffer.f */
src/wbuf_pkg.sv
src/ring_pointer.sv
src/entry_cam.sv
src/entry_regfile.sv
src/wbuf_ctrl.sv
src/wbuf_datapath.sv
src/write_buffer.sv
bench/write_buffer_tb.sv
